/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_l2_tlb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/l2_tlb_trace.txt */
# W cfg_addr cfg_data writes now, B cfg_addr cfg_data writes during the next lookup
# L name vaddr rw hit miss prot coh out_addr, rw 1 = write, all fields hex
W 10 12341B
W 90 ABCDE01
L read_hit 12341567 0 1 0 0 1 ABCDE01567
L write_prot 12341567 1 1 0 1 0 0
L miss_empty_set 55552123 0 0 1 0 0 0
L miss_tag_set1 77771000 0 0 1 0 0 0
W 39 00AB37
W B9 2222222
W 36 00AB37
W B6 3333333
W 37 00AB37
W B7 4444444
L prio_off_way 00AB3FFF 0 1 0 0 0 3333333FFF
W 5F 9ABC5F
W DF 5555555
L last_offset 9ABC5010 1 1 0 0 1 5555555010
W 90 1111111
L new_ppn 12341567 0 1 0 0 1 1111111567
W 36 00BB37
L new_tag_old 00AB3FFF 0 1 0 0 0 4444444FFF
L new_tag_new 00BB3000 0 1 0 0 0 3333333000
B 70 3C3C73
B 71 000000
B F0 7777777
B F1 0
B F2 0
L writes_pending 12341ABC 0 1 0 0 1 1111111ABC
L late_writes 3C3C7ABC 0 1 0 0 0 7777777ABC

/* bench/tb_l2_tlb.sv */
`timescale 1ns/1ps

module tb_l2_tlb;
   import tlb_pkg::*;

   localparam int          LINE_W      = 8 * 128;  // Longest trace line in characters
   localparam int          NAME_W      = 8 * 24;
   localparam int          FILL_CYCLES = N_WAYS * VA_DEPTH;
   localparam logic [31:0] SEED        = 32'h49195486;

   logic                  clk_i;
   logic                  rst_ni;
   logic                  we_i;
   logic [CFG_ADDR_W-1:0] waddr_i;
   logic [CFG_DATA_W-1:0] wdata_i;
   logic                  start_i;
   logic                  busy_o;
   logic [S_ADDR_W-1:0]   in_addr_i;
   logic                  rw_type_i;
   logic                  out_ready_i;
   logic                  out_valid_o;
   logic                  hit_o;
   logic                  miss_o;
   logic                  prot_o;
   logic                  cache_coherent_o;
   logic [M_ADDR_W-1:0]   out_addr_o;

   logic [LINE_W-1:0]     trace_lines [$];
   logic [CFG_ADDR_W-1:0] pend_addr [$];  // Writes issued during the next lookup
   logic [CFG_DATA_W-1:0] pend_data [$];
   int                    cycle_cnt    = 0;
   int                    limit_cycles = 0;  // Zero until the trace is loaded

   l2_tlb UUT (
      .clk_i            ( clk_i            ),
      .rst_ni           ( rst_ni           ),
      .we_i             ( we_i             ),
      .waddr_i          ( waddr_i          ),
      .wdata_i          ( wdata_i          ),
      .start_i          ( start_i          ),
      .busy_o           ( busy_o           ),
      .in_addr_i        ( in_addr_i        ),
      .rw_type_i        ( rw_type_i        ),
      .out_ready_i      ( out_ready_i      ),
      .out_valid_o      ( out_valid_o      ),
      .hit_o            ( hit_o            ),
      .miss_o           ( miss_o           ),
      .prot_o           ( prot_o           ),
      .cache_coherent_o ( cache_coherent_o ),
      .out_addr_o       ( out_addr_o       )
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;  // 4 ns period
   end

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if ((limit_cycles > 0) && (cycle_cnt >= limit_cycles)) begin
         $display("timeout after %0d cycles, the DUT never finished the trace", cycle_cnt);
         $display("tests failed");
         $fatal(1, "run aborted");
      end
   end

   //////////////////////////////
   // Failure reporting

   task automatic report_mismatch(input logic [NAME_W-1:0] test, input string what,
                                  input logic [63:0] exp, input logic [63:0] act);
      $display("error %0s %s: expected %0h, actual %0h", test, what, exp, act);
      $display("tests failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1, "stopped at first error");
   endtask

   //////////////////////////////
   // Trace handling

   task automatic load_trace();
      int                fd;
      int                n;
      logic [LINE_W-1:0] text;
      fd = $fopen("bench/l2_tlb_trace.txt", "r");
      if (fd == 0) begin
         report_failure("cannot open the trace file bench/l2_tlb_trace.txt");
      end
      while (!$feof(fd)) begin
         text = '0;
         n = $fgets(text, fd);
         if (n > 0) begin
            trace_lines.push_back(text);
         end
      end
      $fclose(fd);
   endtask

   task automatic config_write(input logic [CFG_ADDR_W-1:0] addr,
                               input logic [CFG_DATA_W-1:0] data);
      we_i    = 1'b1;
      waddr_i = addr;
      wdata_i = data;
      @(negedge clk_i);
      we_i    = 1'b0;
   endtask

   // Invalid tags everywhere, so unwritten entries never match
   task automatic fill_tags();
      logic [VPN_W-1:0] vpn;
      for (int i = 0; i < FILL_CYCLES; i++) begin
         vpn = VPN_W'(i * 32'h0009_E377);
         config_write(CFG_ADDR_W'(i), CFG_DATA_W'({vpn, 4'b0000}));
      end
   endtask

   task automatic run_lookup(input logic [LINE_W-1:0] text);
      logic [7:0]          kind;
      logic [NAME_W-1:0]   name;
      logic [S_ADDR_W-1:0] va;
      logic                rw;
      logic                e_hit;
      logic                e_miss;
      logic                e_prot;
      logic                e_coh;
      logic [M_ADDR_W-1:0] e_addr;
      logic [3:0]          snap_flags;
      logic [M_ADDR_W-1:0] snap_addr;
      int                  n;
      int                  stall;
      name = '0;
      n = $sscanf(text, "%s %s %h %h %h %h %h %h %h", kind, name, va, rw,
                  e_hit, e_miss, e_prot, e_coh, e_addr);
      if (n != 9) begin
         report_failure("malformed lookup line in the trace");
      end
      while (busy_o) @(negedge clk_i);
      start_i   = 1'b1;
      in_addr_i = va;
      rw_type_i = rw;
      @(negedge clk_i);
      start_i = 1'b0;
      assert (busy_o) else report_failure("busy_o did not rise after start_i");
      fork
         begin
            foreach (pend_addr[i]) begin
               we_i    = 1'b1;
               waddr_i = pend_addr[i];
               wdata_i = pend_data[i];
               @(negedge clk_i);
            end
            we_i = 1'b0;
         end
         begin
            while (!out_valid_o) @(negedge clk_i);  // Bounded by the cycle limit
            snap_flags = {hit_o, miss_o, prot_o, cache_coherent_o};
            snap_addr  = out_addr_o;
            stall      = int'($urandom % 4);
            repeat (stall) begin
               @(negedge clk_i);
               assert (out_valid_o && busy_o)
                  else report_failure("out_valid_o or busy_o dropped under back-pressure");
               assert ({hit_o, miss_o, prot_o, cache_coherent_o} == snap_flags)
                  else report_mismatch(name, "flags under back-pressure", 64'(snap_flags),
                                       64'({hit_o, miss_o, prot_o, cache_coherent_o}));
               assert (out_addr_o == snap_addr)
                  else report_mismatch(name, "out_addr_o under back-pressure",
                                       64'(snap_addr), 64'(out_addr_o));
            end
            assert (hit_o == e_hit) else report_mismatch(name, "hit_o", 64'(e_hit), 64'(hit_o));
            assert (miss_o == e_miss)
               else report_mismatch(name, "miss_o", 64'(e_miss), 64'(miss_o));
            assert (prot_o == e_prot)
               else report_mismatch(name, "prot_o", 64'(e_prot), 64'(prot_o));
            if (e_hit && !e_prot) begin  // Translation only on a clean hit
               assert (cache_coherent_o == e_coh)
                  else report_mismatch(name, "cache_coherent_o", 64'(e_coh),
                                       64'(cache_coherent_o));
               assert (out_addr_o == e_addr)
                  else report_mismatch(name, "out_addr_o", 64'(e_addr), 64'(out_addr_o));
            end
            out_ready_i = 1'b1;
            @(negedge clk_i);
            out_ready_i = 1'b0;
            assert (!out_valid_o) else report_failure("a second result followed the accepted one");
            assert (!busy_o) else report_failure("busy_o stayed high after the result was taken");
         end
      join
      pend_addr.delete();
      pend_data.delete();
   endtask

   task automatic process_line(input logic [LINE_W-1:0] text);
      logic [7:0]            kind;
      logic [CFG_ADDR_W-1:0] addr;
      logic [CFG_DATA_W-1:0] data;
      int                    n;
      kind = 8'h00;  // Blank lines leave it untouched
      n = $sscanf(text, "%s %h %h", kind, addr, data);
      if (((kind == "W") || (kind == "B")) && (n != 3)) begin
         report_failure("malformed write line in the trace");
      end
      if (kind == "W") begin
         config_write(addr, data);
      end else if (kind == "B") begin
         pend_addr.push_back(addr);
         pend_data.push_back(data);
      end else if (kind == "L") begin
         run_lookup(text);
      end
   endtask

   //////////////////////////////
   // Main sequence

   initial begin
      void'($urandom(SEED));
      rst_ni      = 1'b0;
      we_i        = 1'b0;
      waddr_i     = '0;
      wdata_i     = '0;
      start_i     = 1'b0;
      in_addr_i   = '0;
      rw_type_i   = 1'b0;
      out_ready_i = 1'b0;
      load_trace();
      limit_cycles = 40 * trace_lines.size() + 100 + FILL_CYCLES + 4;
      repeat (4) @(negedge clk_i);  // Reset over 4 rising edges
      rst_ni = 1'b1;
      fill_tags();
      foreach (trace_lines[i]) begin
         process_line(trace_lines[i]);
      end
      $display("all tests passed");
      $finish;
   end

endmodule

/* build.f */
hw/tlb_pkg.sv
hw/tlb_hit_if.sv
hw/table_ram.sv
hw/va_way.sv
hw/tlb_search.sv
hw/tlb_result.sv
hw/l2_tlb.sv
bench/tb_l2_tlb.sv

/* hw/l2_tlb.sv */
`timescale 1ns/1ps

module l2_tlb (
   input  logic                           clk_i,
   input  logic                           rst_ni,

   // Config write port
   input  logic                           we_i,
   input  logic [tlb_pkg::CFG_ADDR_W-1:0] waddr_i,
   input  logic [tlb_pkg::CFG_DATA_W-1:0] wdata_i,

   // Lookup request
   input  logic                           start_i,
   output logic                           busy_o,
   input  logic [tlb_pkg::S_ADDR_W-1:0]   in_addr_i,
   input  logic                           rw_type_i,  // 1 = write, 0 = read

   // Held result
   input  logic                           out_ready_i,
   output logic                           out_valid_o,
   output logic                           hit_o,
   output logic                           miss_o,
   output logic                           prot_o,
   output logic                           cache_coherent_o,
   output logic [tlb_pkg::M_ADDR_W-1:0]   out_addr_o
);

   tlb_hit_if hit_if ();

   tlb_search u_search (
      .clk_i     ( clk_i     ),
      .rst_ni    ( rst_ni    ),
      .we_i      ( we_i      ),
      .waddr_i   ( waddr_i   ),
      .wdata_i   ( wdata_i   ),
      .start_i   ( start_i   ),
      .in_addr_i ( in_addr_i ),
      .rw_type_i ( rw_type_i ),
      .busy_o    ( busy_o    ),
      .hit_o     ( hit_if    )
   );

   tlb_result u_result (
      .clk_i            ( clk_i            ),
      .rst_ni           ( rst_ni           ),
      .we_i             ( we_i             ),
      .waddr_i          ( waddr_i          ),
      .wdata_i          ( wdata_i          ),
      .hit_i            ( hit_if           ),
      .out_ready_i      ( out_ready_i      ),
      .out_valid_o      ( out_valid_o      ),
      .hit_o            ( hit_o            ),
      .miss_o           ( miss_o           ),
      .prot_o           ( prot_o           ),
      .cache_coherent_o ( cache_coherent_o ),
      .out_addr_o       ( out_addr_o       )
   );

endmodule

/* hw/table_ram.sv */
`timescale 1ns/1ps

module table_ram #(
   parameter type ENTRY_T = logic,
   parameter int  DEPTH   = 32
) (
   input  logic                     clk_i,
   input  logic                     we_i,
   input  logic [$clog2(DEPTH)-1:0] addr_i,
   input  ENTRY_T                   wdata_i,
   output ENTRY_T                   rdata_o
);

   ENTRY_T mem [0:DEPTH-1];

   // Single port, read-first
   // Data of a read shows up on rdata_o one cycle later
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[addr_i] <= wdata_i;
      end
      rdata_o <= mem[addr_i];
   end

endmodule

/* hw/tlb_hit_if.sv */
`timescale 1ns/1ps

interface tlb_hit_if;
   import tlb_pkg::*;

   logic                 done;      // One-cycle pulse at the end of a search
   logic                 hit;
   logic                 prot;
   logic                 coherent;
   logic [PA_ADDR_W-1:0] pa_index;  // PA table slot of the first match
   logic [PAGE_BITS-1:0] page_off;
   logic                 taken;     // Result accepted by the requester

   // Search side
   modport producer (
      output done, hit, prot, coherent, pa_index, page_off,
      input  taken
   );

   // Result side
   modport consumer (
      input  done, hit, prot, coherent, pa_index, page_off,
      output taken
   );

endinterface

/* hw/tlb_pkg.sv */
package tlb_pkg;

   //////////////////////////////
   // Bus widths
   localparam int S_ADDR_W   = 32;  // Virtual address
   localparam int M_ADDR_W   = 40;  // Physical address
   localparam int CFG_ADDR_W = 32;  // Config word address
   localparam int CFG_DATA_W = 64;

   //////////////////////////////
   // Geometry
   localparam int PAGE_BITS = 12;  // 4 kB pages
   localparam int N_SETS    = 8;
   localparam int SET_W     = $clog2(N_SETS);
   localparam int N_OFFSETS = 4;   // Entries per set in each way
   localparam int OFFSET_W  = $clog2(N_OFFSETS);
   localparam int N_WAYS    = 4;
   localparam int WAY_W     = $clog2(N_WAYS);

   localparam int VA_DEPTH  = N_SETS * N_OFFSETS;
   localparam int VA_ADDR_W = $clog2(VA_DEPTH);
   localparam int PA_DEPTH  = VA_DEPTH * N_WAYS;
   localparam int PA_ADDR_W = $clog2(PA_DEPTH);

   localparam int VPN_W = S_ADDR_W - PAGE_BITS;
   localparam int PPN_W = M_ADDR_W - PAGE_BITS;

   // Config address map
   //   [1:0] way, [6:2] entry index = set * N_OFFSETS + offset
   //   [7]   table select, 0 for the VA ways and 1 for the PA table
   //   PA table slot is [6:0], i.e. entry index * N_WAYS + way

   // Tag entry, taken from the low 24 bits of the config data
   typedef struct packed {
      logic [VPN_W-1:0] vpn;       // Bits 23:4
      logic             coherent;  // Bit 3
      logic             wr_en;     // Bit 2
      logic             rd_en;     // Bit 1
      logic             valid;     // Bit 0
   } va_entry_t;

   // Physical page number
   typedef logic [PPN_W-1:0] pa_entry_t;

endpackage

/* hw/tlb_result.sv */
`timescale 1ns/1ps

module tlb_result (
   input  logic                           clk_i,
   input  logic                           rst_ni,
   input  logic                           we_i,
   input  logic [tlb_pkg::CFG_ADDR_W-1:0] waddr_i,
   input  logic [tlb_pkg::CFG_DATA_W-1:0] wdata_i,
   tlb_hit_if.consumer                    hit_i,
   input  logic                           out_ready_i,
   output logic                           out_valid_o,
   output logic                           hit_o,
   output logic                           miss_o,
   output logic                           prot_o,
   output logic                           cache_coherent_o,
   output logic [tlb_pkg::M_ADDR_W-1:0]   out_addr_o
);
   import tlb_pkg::*;

   typedef enum logic [1:0] {OUT_IDLE, WAIT_ON_WRITE, SEND_OUTPUT} out_state_t;

   out_state_t state_q, state_d;

   logic                 pa_we;
   logic                 pa_rd;       // PA read issued this cycle
   logic                 pa_rd_q;     // PA data on the RAM output
   logic                 clean_hit;
   logic                 report;      // Search report arrives
   logic [PA_ADDR_W-1:0] pa_idx_q;
   logic [PA_ADDR_W-1:0] pa_addr;
   logic [PAGE_BITS-1:0] page_off_q;
   pa_entry_t            pa_rdata;
   pa_entry_t            ppn_q;

   //////////////////////////////
   // PA table

   assign pa_we   = we_i && waddr_i[PA_ADDR_W];  // Bit 7 set selects the PA table
   assign pa_addr = pa_we ? waddr_i[PA_ADDR_W-1:0] : pa_idx_q;

   table_ram #(
      .ENTRY_T ( pa_entry_t ),
      .DEPTH   ( PA_DEPTH   )
   ) u_pa_table (
      .clk_i   ( clk_i              ),
      .we_i    ( pa_we              ),
      .addr_i  ( pa_addr            ),
      .wdata_i ( wdata_i[PPN_W-1:0] ),
      .rdata_o ( pa_rdata           )
   );

   assign clean_hit = hit_i.hit && !hit_i.prot;
   assign report    = (state_q == OUT_IDLE) && hit_i.done;
   assign pa_rd     = (state_q == WAIT_ON_WRITE) && !pa_we;  // Wait while a PA write holds the port

   //////////////////////////////
   // Output FSM

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         OUT_IDLE: begin
            if (hit_i.done) begin
               state_d = clean_hit ? WAIT_ON_WRITE : SEND_OUTPUT;  // Miss and fault skip the PA read
            end
         end
         WAIT_ON_WRITE: begin
            if (pa_rd) begin
               state_d = SEND_OUTPUT;
            end
         end
         SEND_OUTPUT: begin
            if (hit_i.taken) begin
               state_d = OUT_IDLE;
            end
         end
         default: begin
            state_d = OUT_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q          <= OUT_IDLE;
         pa_rd_q          <= 1'b0;
         hit_o            <= 1'b0;
         miss_o           <= 1'b0;
         prot_o           <= 1'b0;
         cache_coherent_o <= 1'b0;
      end else begin
         state_q <= state_d;
         pa_rd_q <= pa_rd;
         if (report) begin
            hit_o            <= hit_i.hit;
            miss_o           <= !hit_i.hit;
            prot_o           <= hit_i.prot;  // Comes with hit set
            cache_coherent_o <= clean_hit && hit_i.coherent;
         end else if (hit_i.taken) begin
            hit_o            <= 1'b0;
            miss_o           <= 1'b0;
            prot_o           <= 1'b0;
            cache_coherent_o <= 1'b0;
         end
      end
   end

   // Held translation
   always_ff @(posedge clk_i) begin
      if (report) begin
         pa_idx_q   <= hit_i.pa_index;
         page_off_q <= hit_i.page_off;
         if (!clean_hit) begin
            ppn_q <= '0;
         end
      end
      if (pa_rd_q) begin
         ppn_q <= pa_rdata;
      end
   end

   // Valid one cycle after the PA data is captured
   assign out_valid_o = (state_q == SEND_OUTPUT) && !pa_rd_q;
   assign out_addr_o  = {ppn_q, page_off_q};
   assign hit_i.taken = out_valid_o && out_ready_i;

endmodule

/* hw/tlb_search.sv */
`timescale 1ns/1ps

module tlb_search (
   input  logic                           clk_i,
   input  logic                           rst_ni,
   input  logic                           we_i,
   input  logic [tlb_pkg::CFG_ADDR_W-1:0] waddr_i,
   input  logic [tlb_pkg::CFG_DATA_W-1:0] wdata_i,
   input  logic                           start_i,
   input  logic [tlb_pkg::S_ADDR_W-1:0]   in_addr_i,
   input  logic                           rw_type_i,
   output logic                           busy_o,
   tlb_hit_if.producer                    hit_o
);
   import tlb_pkg::*;

   typedef enum logic [1:0] {IDLE, SEARCH, DONE} search_state_t;

   search_state_t state_q, state_d;

   logic [S_ADDR_W-1:0]  addr_q;      // Latched lookup address
   logic                 rw_q;
   logic [OFFSET_W-1:0]  off_q;       // Next offset to read
   logic [OFFSET_W-1:0]  rd_off_q;    // Offset of the data on the RAM outputs
   logic                 rd_valid_q;  // RAM outputs hold fresh search data
   logic                 rd_issue;
   logic                 va_wr;

   logic [SET_W-1:0]     set_num;
   logic [VPN_W-1:0]     vpn;
   logic [VA_ADDR_W-1:0] search_addr;
   va_entry_t            va_wdata;

   logic [N_WAYS-1:0]                way_we;
   logic [N_WAYS-1:0][VA_ADDR_W-1:0] way_addr;
   logic [N_WAYS-1:0]                way_match;
   logic [N_WAYS-1:0]                way_prot;
   logic [N_WAYS-1:0]                way_coh;

   logic             any_match;
   logic [WAY_W-1:0] sel_way;     // Lowest matching way
   logic             last_off;
   logic             search_end;

   assign set_num     = addr_q[PAGE_BITS +: SET_W];
   assign vpn         = addr_q[S_ADDR_W-1:PAGE_BITS];
   assign search_addr = {set_num, off_q};

   //////////////////////////////
   // VA ways and write decode

   assign va_wr    = we_i && !waddr_i[PA_ADDR_W];  // Bit 7 clear selects the VA ways
   assign va_wdata = wdata_i[$bits(va_entry_t)-1:0];

   for (genvar w = 0; w < N_WAYS; w++) begin : g_way
      assign way_we[w]   = va_wr && (waddr_i[WAY_W-1:0] == WAY_W'(w));
      assign way_addr[w] = way_we[w] ? waddr_i[WAY_W +: VA_ADDR_W] : search_addr;

      va_way u_way (
         .clk_i      ( clk_i        ),
         .we_i       ( way_we[w]    ),
         .addr_i     ( way_addr[w]  ),
         .wdata_i    ( va_wdata     ),
         .vpn_i      ( vpn          ),
         .rw_type_i  ( rw_q         ),
         .match_o    ( way_match[w] ),
         .prot_o     ( way_prot[w]  ),
         .coherent_o ( way_coh[w]   )
      );
   end

   //////////////////////////////
   // First-match selection

   always_comb begin
      sel_way = '0;
      for (int i = N_WAYS - 1; i >= 0; i--) begin
         if (way_match[i]) begin
            sel_way = WAY_W'(i);
         end
      end
   end

   assign any_match  = |way_match;
   assign last_off   = (rd_off_q == OFFSET_W'(N_OFFSETS - 1));
   assign search_end = (state_q == SEARCH) && rd_valid_q && (any_match || last_off);

   // A VA write owns the RAM port and pauses the walk
   assign rd_issue = (state_q == SEARCH) && !va_wr && !search_end;

   //////////////////////////////
   // FSM

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         IDLE: begin
            if (start_i) begin
               state_d = SEARCH;
            end
         end
         SEARCH: begin
            if (search_end) begin
               state_d = DONE;
            end
         end
         DONE: begin
            if (hit_o.taken) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q    <= IDLE;
         off_q      <= '0;
         rd_valid_q <= 1'b0;
      end else begin
         state_q    <= state_d;
         rd_valid_q <= rd_issue;
         if (state_q == IDLE) begin
            off_q <= '0;  // Every walk starts at offset 0
         end else if (rd_issue) begin
            off_q <= off_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if ((state_q == IDLE) && start_i) begin
         addr_q <= in_addr_i;
         rw_q   <= rw_type_i;
      end
      if (rd_issue) begin
         rd_off_q <= off_q;
      end
   end

   assign busy_o = (state_q != IDLE);

   // Report, meaningful only while done is high
   assign hit_o.done     = search_end;
   assign hit_o.hit      = any_match;
   assign hit_o.prot     = way_prot[sel_way];
   assign hit_o.coherent = way_coh[sel_way];
   assign hit_o.pa_index = {set_num, rd_off_q, sel_way};  // Entry index * N_WAYS + way
   assign hit_o.page_off = addr_q[PAGE_BITS-1:0];

endmodule

/* hw/va_way.sv */
`timescale 1ns/1ps

module va_way (
   input  logic                          clk_i,
   input  logic                          we_i,
   input  logic [tlb_pkg::VA_ADDR_W-1:0] addr_i,
   input  tlb_pkg::va_entry_t            wdata_i,
   input  logic [tlb_pkg::VPN_W-1:0]     vpn_i,
   input  logic                          rw_type_i,  // 1 = write, 0 = read
   output logic                          match_o,
   output logic                          prot_o,
   output logic                          coherent_o
);
   import tlb_pkg::*;

   va_entry_t entry;    // Tag read one cycle earlier
   logic      allowed;  // Access type permitted by the entry

   table_ram #(
      .ENTRY_T ( va_entry_t ),
      .DEPTH   ( VA_DEPTH   )
   ) u_tags (
      .clk_i   ( clk_i   ),
      .we_i    ( we_i    ),
      .addr_i  ( addr_i  ),
      .wdata_i ( wdata_i ),
      .rdata_o ( entry   )
   );

   //////////////////////////////
   // Tag and permission check

   assign match_o = entry.valid && (entry.vpn == vpn_i);

   assign allowed = rw_type_i ? entry.wr_en : entry.rd_en;

   // Fault only counts on a real match
   assign prot_o     = match_o && !allowed;
   assign coherent_o = match_o && entry.coherent;

endmodule
